// ==== fmul_pkg.sv ====
`default_nettype none

package fmul_pkg;

  // ==================================================
  // Word geometry
  // ==================================================
  localparam int WORD_W    = 32;
  localparam int EXPN_W    = 8;
  localparam int FRAC_W    = 23;
  localparam int EXPN_BIAS = 127;
  localparam int EXPN_MAX  = 255;

  // Significand with hidden bit, full product, exponent with guard bits
  localparam int SIG_W   = FRAC_W + 1;
  localparam int PROD_W  = 2 * SIG_W;
  localparam int EXPNT_W = EXPN_W + 2;

  // ==================================================
  // Multiplier row geometry
  // ==================================================
  // ROW_BITS * NUM_ROWS covers all SIG_W multiplier bits
  localparam int ROW_BITS = 6;
  localparam int NUM_ROWS = 4;

  // ==================================================
  // Types
  // ==================================================
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [SIG_W-1:0]   sig_t;
  typedef logic [EXPNT_W-1:0] expnt_t;
  typedef logic [PROD_W-1:0]  prod_t;

  typedef enum logic [1:0] {
    rm_rne = 2'd0,
    rm_rtz = 2'd1,
    rm_rdn = 2'd2,
    rm_rup = 2'd3
  } rm_t;

  typedef struct packed {
    logic of;
    logic uf;
    logic nx;
  } exc_t;

  // One item travelling down the pipe
  typedef struct packed {
    logic   vld;
    logic   sign;
    logic   zero;
    rm_t    rm;
    // Biased exponent of the product before normalisation
    expnt_t expnt;
    sig_t   sig_a;
    sig_t   sig_b;
    // Running sum of partial products
    prod_t  acc;
  } mul_stage_t;

endpackage

`default_nettype wire

// ==== fmul_unpack.sv ====
`timescale 1ns/1ns
`default_nettype none

module fmul_unpack
  import fmul_pkg::*;
(
  input  logic       fmau_ex2_data_clk,
  input  logic       rst_n,
  input  logic       stall,
  input  logic       in_vld,
  input  word_t      a,
  input  word_t      b,
  input  logic       neg,
  input  rm_t        rm,
  output mul_stage_t stage_out
);

  logic [EXPN_W-1:0] expn_a;
  logic [EXPN_W-1:0] expn_b;
  logic              zero_a;
  logic              zero_b;
  mul_stage_t        stage_d;
  mul_stage_t        stage_q;

  // ==================================================
  // Operand decode
  // ==================================================
  assign expn_a = a[WORD_W-2 -: EXPN_W];
  assign expn_b = b[WORD_W-2 -: EXPN_W];

  // Zero exponent field counts as zero, no subnormal inputs
  assign zero_a = ~|expn_a;
  assign zero_b = ~|expn_b;

  always_comb
  begin
    stage_d = '0;

    stage_d.vld  = in_vld;
    stage_d.rm   = rm;
    stage_d.zero = zero_a | zero_b;

    // Sign includes the negate bit
    stage_d.sign = a[WORD_W-1] ^ b[WORD_W-1] ^ neg;

    // Hidden bit set for normal operands
    stage_d.sig_a = {~zero_a, a[FRAC_W-1:0]};
    stage_d.sig_b = {~zero_b, b[FRAC_W-1:0]};

    // Sum of biased exponents minus one bias
    stage_d.expnt = expnt_t'(expn_a) + expnt_t'(expn_b) - expnt_t'(EXPN_BIAS);

    // Rows fill the accumulator
    stage_d.acc = '0;
  end

  // ==================================================
  // EX1 register
  // ==================================================
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      stage_q.vld <= 1'b0;
    end
    else if (!stall)
    begin
      stage_q <= stage_d;
    end
  end

  assign stage_out = stage_q;

endmodule

`default_nettype wire

// ==== fmul_pp_row.sv ====
`timescale 1ns/1ns
`default_nettype none

module fmul_pp_row
  import fmul_pkg::*;
#(
  parameter int ROW_IDX = 0
)
(
  input  logic       fmau_ex2_data_clk,
  input  logic       rst_n,
  input  logic       stall,
  input  mul_stage_t stage_in,
  output mul_stage_t stage_out
);

  // First multiplier bit handled by this row
  localparam int BASE = ROW_IDX * ROW_BITS;

  prod_t      acc_d;
  mul_stage_t stage_d;
  mul_stage_t stage_q;

  // Shift-and-add over this row's slice of sig_b
  always_comb
  begin
    acc_d = stage_in.acc;
    for (int i = 0; i < ROW_BITS; i++)
    begin
      if ((BASE + i) < SIG_W)
      begin
        if (stage_in.sig_b[BASE + i])
        begin
          acc_d = acc_d + (prod_t'(stage_in.sig_a) << (BASE + i));
        end
      end
    end
  end

  // Everything else passes straight through
  always_comb
  begin
    stage_d     = stage_in;
    stage_d.acc = acc_d;
  end

  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      stage_q.vld <= 1'b0;
    end
    else if (!stall)
    begin
      stage_q <= stage_d;
    end
  end

  assign stage_out = stage_q;

endmodule

`default_nettype wire

// ==== fmul_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module fmul_round
  import fmul_pkg::*;
(
  input  logic       fmau_ex2_data_clk,
  input  logic       rst_n,
  input  logic       stall,
  input  mul_stage_t stage_in,
  output logic       out_vld,
  output word_t      result,
  output exc_t       exc
);

  prod_t            norm;
  sig_t             mant;
  logic             guard;
  logic             sticky;
  expnt_t           exp_norm;
  expnt_t           exp_rnd;
  logic             round_up;
  logic [SIG_W:0]   mant_rnd;
  logic             carry;
  logic [FRAC_W-1:0] frac_rnd;
  logic             ovf_to_inf;
  logic             is_of;
  logic             is_uf;
  word_t            res_d;
  exc_t             exc_d;

  // ==================================================
  // Normalise
  // ==================================================
  // Product is in [1,4) so a set top bit means 2 or more
  assign norm     = stage_in.acc[PROD_W-1] ? stage_in.acc : (stage_in.acc << 1);
  assign exp_norm = stage_in.expnt + expnt_t'(stage_in.acc[PROD_W-1]);

  assign mant   = norm[PROD_W-1 -: SIG_W];
  assign guard  = norm[PROD_W-SIG_W-1];
  assign sticky = |norm[PROD_W-SIG_W-2:0];

  // ==================================================
  // Round
  // ==================================================
  always_comb
  begin
    round_up   = 1'b0;
    ovf_to_inf = 1'b0;
    unique case (stage_in.rm)
      rm_rne:
      begin
        round_up   = guard & (sticky | mant[0]);
        ovf_to_inf = 1'b1;
      end
      rm_rtz:
      begin
        round_up   = 1'b0;
        ovf_to_inf = 1'b0;
      end
      rm_rdn:
      begin
        round_up   = stage_in.sign & (guard | sticky);
        ovf_to_inf = stage_in.sign;
      end
      rm_rup:
      begin
        round_up   = ~stage_in.sign & (guard | sticky);
        ovf_to_inf = ~stage_in.sign;
      end
    endcase
  end

  assign mant_rnd = {1'b0, mant} + {{SIG_W{1'b0}}, round_up};
  assign carry    = mant_rnd[SIG_W];

  // On carry out the low bits are already zero and the value is 1.0 x 2^(e+1)
  assign frac_rnd = mant_rnd[FRAC_W-1:0];
  assign exp_rnd  = exp_norm + expnt_t'(carry);

  // Underflow judged before rounding, overflow after
  assign is_uf = ($signed(exp_norm) <= 0);
  assign is_of = ($signed(exp_rnd) >= $signed(expnt_t'(EXPN_MAX)));

  // ==================================================
  // Result select
  // ==================================================
  always_comb
  begin
    exc_d = '0;
    res_d = {stage_in.sign, exp_rnd[EXPN_W-1:0], frac_rnd};

    if (stage_in.zero)
    begin
      res_d = {stage_in.sign, {(WORD_W-1){1'b0}}};
    end
    else if (is_uf)
    begin
      // Flush to signed zero
      res_d    = {stage_in.sign, {(WORD_W-1){1'b0}}};
      exc_d.uf = 1'b1;
      exc_d.nx = 1'b1;
    end
    else if (is_of)
    begin
      exc_d.of = 1'b1;
      exc_d.nx = 1'b1;
      if (ovf_to_inf)
      begin
        res_d = {stage_in.sign, EXPN_W'(EXPN_MAX), {FRAC_W{1'b0}}};
      end
      else
      begin
        // Largest finite value
        res_d = {stage_in.sign, EXPN_W'(EXPN_MAX - 1), {FRAC_W{1'b1}}};
      end
    end
    else
    begin
      exc_d.nx = guard | sticky;
    end
  end

  // ==================================================
  // Output register
  // ==================================================
  always_ff @(posedge fmau_ex2_data_clk)
  begin
    if (!rst_n)
    begin
      out_vld <= 1'b0;
      result  <= '0;
      exc     <= '0;
    end
    else if (!stall)
    begin
      out_vld <= stage_in.vld;
      // Hold last result across bubbles
      if (stage_in.vld)
      begin
        result <= res_d;
        exc    <= exc_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fmul_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fmul_top
  import fmul_pkg::*;
(
  input  logic  fmau_ex2_data_clk,
  input  logic  rst_n,
  input  logic  in_vld,
  input  word_t a,
  input  word_t b,
  input  logic  neg,
  input  rm_t   rm,
  input  logic  stall,
  output logic  out_vld,
  output word_t result,
  output exc_t  exc
);

  // stage[k] feeds row k, stage[NUM_ROWS] feeds rounding
  mul_stage_t stage [0:NUM_ROWS];

  // ==================================================
  // EX1 unpack
  // ==================================================
  fmul_unpack u_unpack (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .in_vld            (in_vld),
    .a                 (a),
    .b                 (b),
    .neg               (neg),
    .rm                (rm),
    .stage_out         (stage[0])
  );

  // ==================================================
  // Partial product rows
  // ==================================================
  for (genvar k = 0; k < NUM_ROWS; k++)
  begin : g_row
    fmul_pp_row #(
      .ROW_IDX (k)
    ) u_pp_row (
      .fmau_ex2_data_clk (fmau_ex2_data_clk),
      .rst_n             (rst_n),
      .stall             (stall),
      .stage_in          (stage[k]),
      .stage_out         (stage[k+1])
    );
  end

  // ==================================================
  // Normalise and round
  // ==================================================
  fmul_round u_round (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .stage_in          (stage[NUM_ROWS]),
    .out_vld           (out_vld),
    .result            (result),
    .exc               (exc)
  );

endmodule

`default_nettype wire

// ==== fmul_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module fmul_props
  import fmul_pkg::*;
(
  input logic  fmau_ex2_data_clk,
  input logic  rst_n,
  input logic  stall,
  input logic  out_vld,
  input word_t result,
  input exc_t  exc
);

  // Outputs frozen across a stalled edge
  a_stall_hold : assert property (
    @(posedge fmau_ex2_data_clk) disable iff (!rst_n)
    stall |=> ($stable(result) && $stable(exc) && $stable(out_vld))
  ) else $error("outputs changed across a stalled edge");

  a_of_nx : assert property (
    @(posedge fmau_ex2_data_clk) exc.of |-> exc.nx
  ) else $error("of set without nx");

  // Flushed results carry no fraction
  a_zero_exp : assert property (
    @(posedge fmau_ex2_data_clk)
    (result[WORD_W-2 -: EXPN_W] == '0) |-> (result[FRAC_W-1:0] == '0)
  ) else $error("zero exponent with nonzero fraction");

  a_reset_vld : assert property (
    @(posedge fmau_ex2_data_clk) !rst_n |=> !out_vld
  ) else $error("out_vld high after reset");

endmodule

bind fmul_top fmul_props u_fmul_props (.*);

`default_nettype wire

// ==== tb_fmul.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fmul
  import fmul_pkg::*;
();

  localparam int MAX_VEC = 64;

  // Vector columns are behaviour, rm, a, b, neg, result and exc
  logic [111:0] vec_mem [0:MAX_VEC-1];

  logic   fmau_ex2_data_clk;
  logic   rst_n;
  logic   in_vld;
  word_t  a;
  word_t  b;
  logic   neg;
  rm_t    rm;
  logic   stall;
  logic   out_vld;
  word_t  result;
  exc_t   exc;

  integer seed;
  int     num_vec;
  logic   loaded;
  logic   adv_edge;
  int     exp_q [$];
  int     err_count;
  int     check_count;
  int     recv_count;

  fmul_top u_fmul_top (
    .fmau_ex2_data_clk (fmau_ex2_data_clk),
    .rst_n             (rst_n),
    .in_vld            (in_vld),
    .a                 (a),
    .b                 (b),
    .neg               (neg),
    .rm                (rm),
    .stall             (stall),
    .out_vld           (out_vld),
    .result            (result),
    .exc               (exc)
  );

  initial
  begin
    fmau_ex2_data_clk = 1'b0;
  end

  always #2 fmau_ex2_data_clk = ~fmau_ex2_data_clk;

  // ==================================================
  // Helpers
  // ==================================================
  task automatic load_vectors();
    for (int i = 0; i < MAX_VEC; i++)
    begin
      vec_mem[i] = '0;
    end
    $readmemh("fmul_testdata.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[num_vec][111:108] != 4'h0)
    begin
      num_vec++;
    end
  endtask

  task automatic apply_vector(input int idx);
    logic [111:0] v;
    v   = vec_mem[idx];
    rm  = rm_t'(v[105:104]);
    a   = v[103:72];
    b   = v[71:40];
    neg = v[36];
  endtask

  // Hold the vector until an edge without stall takes it
  task automatic offer_vector(input int idx, input logic use_stall);
    logic taken;
    taken = 1'b0;
    while (!taken)
    begin
      @(negedge fmau_ex2_data_clk);
      apply_vector(idx);
      in_vld = 1'b1;
      stall  = use_stall ? (($random(seed) & 3) == 0) : 1'b0;
      @(posedge fmau_ex2_data_clk);
      if (!stall)
      begin
        exp_q.push_back(idx);
        taken = 1'b1;
      end
    end
  endtask

  task automatic check_output();
    int           idx;
    logic [111:0] v;
    logic         bad;
    if (exp_q.size() == 0)
    begin
      err_count++;
      $display("Unexpected out_vld pulse with no vector in flight");
    end
    else
    begin
      idx = exp_q.pop_front();
      v   = vec_mem[idx];
      bad = 1'b0;
      recv_count++;
      check_count++;
      if (result !== v[35:4])
      begin
        $display("Error: result got %h expected %h (vector %0d)", result, v[35:4], idx);
        bad = 1'b1;
      end
      check_count++;
      if (exc !== v[2:0])
      begin
        $display("Error: exc got %h expected %h (vector %0d)", exc, v[2:0], idx);
        bad = 1'b1;
      end
      if (bad)
      begin
        err_count++;
      end
      $display("Vector %0d behaviour %0d: %s", idx, v[111:108], bad ? "FAIL" : "pass");
    end
  endtask

  // ==================================================
  // Output monitor
  // ==================================================
  // New output only after an edge that advanced the pipe
  always @(posedge fmau_ex2_data_clk)
  begin
    adv_edge <= rst_n && !stall;
  end

  always @(negedge fmau_ex2_data_clk)
  begin
    if (adv_edge && out_vld)
    begin
      check_output();
    end
  end

  // ==================================================
  // Watchdog
  // ==================================================
  initial
  begin
    wait (loaded);
    repeat (num_vec * 20 + 100) @(posedge fmau_ex2_data_clk);
    $display("Timeout: the run did not finish within %0d cycles", num_vec * 20 + 100);
    $display("Checks failed");
    $finish;
  end

  // ==================================================
  // Main sequence
  // ==================================================
  initial
  begin
    int edges;
    int err_snap;
    seed        = 32'hd2c87ed4;
    rst_n       = 1'b0;
    in_vld      = 1'b0;
    a           = '0;
    b           = '0;
    neg         = 1'b0;
    rm          = rm_rne;
    stall       = 1'b0;
    err_count   = 0;
    check_count = 0;
    recv_count  = 0;
    loaded      = 1'b0;
    load_vectors();
    loaded = 1'b1;
    if (num_vec == 0)
    begin
      err_count++;
      $display("No test vectors were read from fmul_testdata.txt");
    end
    repeat (2) @(posedge fmau_ex2_data_clk);
    @(negedge fmau_ex2_data_clk);
    rst_n = 1'b1;

    // Behaviour 6 sends the first item through an idle pipe
    err_snap = err_count;
    repeat (4)
    begin
      @(negedge fmau_ex2_data_clk);
      if (out_vld)
      begin
        err_count++;
        $display("out_vld went high before any input was accepted");
      end
    end
    if (num_vec > 0)
    begin
      offer_vector(0, 1'b0);
      @(negedge fmau_ex2_data_clk);
      in_vld = 1'b0;
      edges  = 1;
      while (!out_vld && edges < 12)
      begin
        @(posedge fmau_ex2_data_clk);
        edges++;
        @(negedge fmau_ex2_data_clk);
      end
      if (edges != 6)
      begin
        err_count++;
        $display("First result arrived after %0d edges instead of 6", edges);
      end
      @(negedge fmau_ex2_data_clk);
      if (out_vld)
      begin
        err_count++;
        $display("out_vld stayed high for more than one cycle");
      end
    end
    $display("Behaviour 6: %s", (err_count == err_snap) ? "pass" : "FAIL");

    // Behaviour 5 runs the remaining vectors back to back under random stall
    err_snap = err_count;
    for (int i = 1; i < num_vec; i++)
    begin
      offer_vector(i, 1'b1);
    end
    @(negedge fmau_ex2_data_clk);
    in_vld = 1'b0;
    while (exp_q.size() > 0)
    begin
      @(negedge fmau_ex2_data_clk);
      stall = (($random(seed) & 3) == 0);
    end
    stall = 1'b0;
    repeat (10) @(negedge fmau_ex2_data_clk);
    if (recv_count != num_vec)
    begin
      err_count++;
      $display("Received %0d results for %0d vectors", recv_count, num_vec);
    end
    $display("Behaviour 5: %s", (err_count == err_snap) ? "pass" : "FAIL");

    $display("Summary: %0d checks, %0d errors, %0d of %0d results received",
             check_count, err_count, recv_count, num_vec);
    if (err_count == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fmul_testdata.txt ====
// Columns: behaviour_rm_a_b_neg_result_exc, exc bits are of uf nx
// Behaviour 1 exact, 2 inexact, 3 zero operand, 4 overflow and underflow
1_0_3f800000_3f800000_0_3f800000_0
1_1_40000000_40400000_0_40c00000_0
1_2_3fc00000_3fc00000_0_40100000_0
1_3_c0000000_3f000000_0_bf800000_0
1_0_3f800000_3f800000_1_bf800000_0
1_0_00800000_3f800000_0_00800000_0
2_0_3f800001_3f800001_0_3f800002_1
2_3_3f800001_3f800001_0_3f800003_1
2_1_3f800001_3f800001_0_3f800002_1
2_2_bf800001_3f800001_0_bf800003_1
2_3_bf800001_3f800001_0_bf800002_1
2_0_3f800001_3fc00000_0_3fc00002_1
2_0_3f800003_3fc00000_0_3fc00004_1
2_3_3f800003_3fc00000_0_3fc00005_1
2_0_3fc00000_3fc00001_0_40100001_1
2_0_3ffffffe_3f800001_0_40000000_1
2_1_3ffffffe_3f800001_0_3fffffff_1
3_0_00000000_3f800000_0_00000000_0
3_0_3f800000_80000000_0_80000000_0
3_1_00000000_00000000_1_80000000_0
3_2_80000000_c0000000_1_80000000_0
3_3_40400000_00000000_1_80000000_0
4_0_7f000000_40000000_0_7f800000_5
4_1_7f000000_40000000_0_7f7fffff_5
4_2_7f000000_40000000_0_7f7fffff_5
4_3_7f000000_40000000_0_7f800000_5
4_2_ff000000_40000000_0_ff800000_5
4_3_ff000000_40000000_0_ff7fffff_5
4_0_00800000_3f000000_0_00000000_3
4_0_80800000_3f000000_0_80000000_3
4_1_00800000_00800000_0_00000000_3

// ==== fmul.f ====
fmul_pkg.sv
fmul_unpack.sv
fmul_pp_row.sv
fmul_round.sv
fmul_top.sv
fmul_props.sv
tb_fmul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fmul -f fmul.f \
  -o sim_fmul > build.log 2>&1 \
  && ./obj_dir/sim_fmul > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "All checks passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
